// ==== common/mult_pkg.sv ====
package mult_pkg;

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;
    localparam int OPERAND_W = 16;
    localparam int RESULT_FIFO_DEPTH = 4;
    localparam int RESULT_COUNT_W = $clog2(RESULT_FIFO_DEPTH + 1);

    // Register byte offsets
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_OPERANDS = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_RESULT = 4'hC;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] aw_addr;
        logic aw_valid;
        logic [AXIL_DATA_W-1:0] w_data;
        logic [AXIL_DATA_W/8-1:0] w_strb;
        logic w_valid;
        logic b_ready;
        logic [AXIL_ADDR_W-1:0] ar_addr;
        logic ar_valid;
        logic r_ready;
    } axil_req_t;

    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic [1:0] b_resp;
        logic b_valid;
        logic ar_ready;
        logic [AXIL_DATA_W-1:0] r_data;
        logic [1:0] r_resp;
        logic r_valid;
    } axil_rsp_t;

    typedef struct packed {
        logic signed [OPERAND_W-1:0] x;
        logic signed [OPERAND_W-1:0] y;
        logic approx; // 1 selects the approximate multiplier
    } mult_job_t;

    typedef struct packed {
        logic [2*OPERAND_W-1:0] product;
        logic approx;
    } mult_result_t;

endpackage

// ==== hdl/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // Takes new data when empty or when the current word leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== hdl/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_valid,
    input  mult_pkg::mult_result_t              wr_data,
    output logic                                wr_ready,
    input  logic                                pop,
    output mult_pkg::mult_result_t              head,
    output logic                                empty,
    output logic [mult_pkg::RESULT_COUNT_W-1:0] count
);

    localparam int PTR_W = $clog2(mult_pkg::RESULT_FIFO_DEPTH);

    mult_pkg::mult_result_t mem [mult_pkg::RESULT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic full;
    logic push;

    assign full = (count == mult_pkg::RESULT_COUNT_W'(mult_pkg::RESULT_FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_ready = !full || pop; // A pop frees the slot in the same cycle
    assign push = wr_valid && wr_ready;
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== mult_core/mult_approx_bw16.sv ====
`timescale 1ns/1ps

module mult_approx_bw16 (
    input  logic signed [15:0] x,
    input  logic signed [15:0] y,
    output logic        [31:0] z
);

    logic [15:0] pp [16];
    logic [20:0] comp [5];
    logic [31:0] acc;

    // Baugh-Wooley rows, sign column inverted
    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i][14:0] = y[14:0] & {15{x[i]}};
            pp[i][15] = ~(y[15] & x[i]);
        end
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15] = y[15] & x[15];
    end

    // Sparse stand-in for rows 0 to 5
    always_comb begin
        for (int k = 0; k < 5; k++) begin
            comp[k] = '0;
        end
        comp[0][2] = pp[0][2] ^ pp[1][1];
        comp[0][3] = pp[2][1] ^ pp[3][0];
        comp[0][4] = pp[2][2] ^ pp[3][1];
        comp[0][6] = pp[0][6] ^ pp[1][5];
        comp[0][7] = pp[2][5] ^ pp[3][4];
        comp[0][9] = pp[2][7] ^ pp[3][6];
        comp[0][10] = pp[0][9] & pp[1][8];
        comp[0][12] = pp[0][12] ^ pp[1][11];
        comp[0][13] = pp[2][10] & pp[3][9];
        comp[0][14] = pp[2][11] & pp[3][10];
        comp[0][15] = pp[0][14] & pp[1][13];
        comp[0][16] = ~pp[1][15]; // Correction one at column 16 folded in
        comp[0][17] = pp[1][15];
        comp[0][18] = pp[2][15] | pp[3][14];
        comp[0][19] = pp[4][14] & pp[5][13];
        comp[0][20] = pp[4][15] & pp[5][14];

        comp[1][10] = pp[2][7] & pp[3][6];
        comp[1][13] = pp[4][8] & pp[5][7];
        comp[1][15] = pp[0][15] ^ pp[1][14];
        comp[1][17] = pp[2][14] ^ pp[3][13];
        comp[1][18] = pp[4][13] & pp[5][12];
        comp[1][19] = pp[4][15] ^ pp[5][14];
        comp[1][20] = pp[5][15];

        comp[2][15] = pp[2][13] ^ pp[3][12];
        comp[2][17] = pp[2][15] ^ pp[3][14];
        comp[2][18] = pp[4][14] ^ pp[5][13];

        comp[3][17] = pp[4][12] | pp[5][11];

        comp[4][17] = pp[4][13] ^ pp[5][12];
    end

    always_comb begin
        acc = 32'h8000_0000; // Correction one at column 31
        for (int i = 6; i < 16; i++) begin
            acc = acc + (32'(pp[i]) << i);
        end
        for (int k = 0; k < 5; k++) begin
            acc = acc + 32'(comp[k]);
        end
        z = acc;
    end

endmodule

// ==== mult_core/mult_datapath.sv ====
`timescale 1ns/1ps

module mult_datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  mult_pkg::mult_job_t    in_job,
    output logic                   in_ready,
    output logic                   out_valid,
    output mult_pkg::mult_result_t out_res,
    input  logic                   out_ready
);

    logic s1_valid;
    logic s1_ready;
    mult_pkg::mult_job_t s1_job;
    logic signed [31:0] exact_prod;
    logic [31:0] approx_prod;
    mult_pkg::mult_result_t mid_res;

    pipe_stage #(
        .payload_t(mult_pkg::mult_job_t)
    ) job_stage_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_data(in_job),
        .in_ready(in_ready),
        .out_valid(s1_valid),
        .out_data(s1_job),
        .out_ready(s1_ready)
    );

    mult_approx_bw16 approx_inst (
        .x(s1_job.x),
        .y(s1_job.y),
        .z(approx_prod)
    );

    assign exact_prod = s1_job.x * s1_job.y;

    always_comb begin
        mid_res.product = s1_job.approx ? approx_prod : exact_prod;
        mid_res.approx = s1_job.approx;
    end

    pipe_stage #(
        .payload_t(mult_pkg::mult_result_t)
    ) res_stage_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(s1_valid),
        .in_data(mid_res),
        .in_ready(s1_ready), // FIFO stall reaches back to stage one
        .out_valid(out_valid),
        .out_data(out_res),
        .out_ready(out_ready)
    );

endmodule

// ==== hdl/axil_mult_regs.sv ====
`timescale 1ns/1ps

module axil_mult_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  mult_pkg::axil_req_t                     axil_req,
    output mult_pkg::axil_rsp_t                     axil_rsp,
    output logic                                    job_valid,
    output mult_pkg::mult_job_t                     job,
    input  logic                                    job_ready,
    input  mult_pkg::mult_result_t                  res_data,
    input  logic                                    res_empty,
    input  logic [mult_pkg::RESULT_COUNT_W-1:0]     res_count,
    output logic                                    res_pop
);

    logic mode;
    logic b_valid;
    logic [1:0] b_resp;
    logic r_valid;
    logic [mult_pkg::AXIL_DATA_W-1:0] r_data;
    logic [1:0] r_resp;

    logic wr_full_strb;
    logic wr_need_job;
    logic wr_go;
    logic rd_go;
    logic [1:0] wr_resp;
    logic [mult_pkg::AXIL_DATA_W-1:0] rd_data;
    logic [1:0] rd_resp;

    assign wr_full_strb = &axil_req.w_strb; // Partial writes change nothing
    assign wr_need_job = wr_full_strb && (axil_req.aw_addr == mult_pkg::REG_OPERANDS);

    // AW and W are taken together, OPERANDS also waits for the datapath
    assign job_valid = axil_req.aw_valid && axil_req.w_valid && !b_valid && wr_need_job;
    assign wr_go = axil_req.aw_valid && axil_req.w_valid && !b_valid &&
                   (!wr_need_job || job_ready);

    assign job.x = axil_req.w_data[15:0];
    assign job.y = axil_req.w_data[31:16];
    assign job.approx = mode;

    assign rd_go = axil_req.ar_valid && !r_valid;
    assign res_pop = rd_go && (axil_req.ar_addr == mult_pkg::REG_RESULT) && !res_empty;

    always_comb begin
        case (axil_req.aw_addr)
            mult_pkg::REG_CTRL,
            mult_pkg::REG_OPERANDS,
            mult_pkg::REG_STATUS,
            mult_pkg::REG_RESULT: wr_resp = mult_pkg::AXI_RESP_OKAY; // RO writes dropped
            default: wr_resp = mult_pkg::AXI_RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = mult_pkg::AXI_RESP_OKAY;
        case (axil_req.ar_addr)
            mult_pkg::REG_CTRL: rd_data[0] = mode;
            mult_pkg::REG_OPERANDS: rd_data = '0; // Write only
            mult_pkg::REG_STATUS: begin
                rd_data[0] = !res_empty;
                rd_data[1] = !job_ready;
                rd_data[2 +: mult_pkg::RESULT_COUNT_W] = res_count;
            end
            mult_pkg::REG_RESULT: begin
                if (res_empty) begin
                    rd_resp = mult_pkg::AXI_RESP_SLVERR;
                end else begin
                    rd_data = res_data.product;
                end
            end
            default: rd_resp = mult_pkg::AXI_RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
            mode <= 1'b0; // Exact mode
        end else begin
            if (wr_go) begin
                b_valid <= 1'b1;
            end else if (axil_req.b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_go) begin
                r_valid <= 1'b1;
            end else if (axil_req.r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_go && wr_full_strb && (axil_req.aw_addr == mult_pkg::REG_CTRL)) begin
                mode <= axil_req.w_data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            b_resp <= wr_resp;
        end
        if (rd_go) begin
            r_data <= rd_data;
            r_resp <= rd_resp;
        end
    end

    always_comb begin
        axil_rsp.aw_ready = wr_go;
        axil_rsp.w_ready = wr_go;
        axil_rsp.b_resp = b_resp;
        axil_rsp.b_valid = b_valid;
        axil_rsp.ar_ready = rd_go; // Low while a read response is pending
        axil_rsp.r_data = r_data;
        axil_rsp.r_resp = r_resp;
        axil_rsp.r_valid = r_valid;
    end

endmodule

// ==== hdl/mult_top.sv ====
`timescale 1ns/1ps

module mult_top (
    input  logic                clk,
    input  logic                rst,
    input  mult_pkg::axil_req_t axil_req,
    output mult_pkg::axil_rsp_t axil_rsp
);

    logic job_valid;
    logic job_ready;
    mult_pkg::mult_job_t job;
    logic res_valid;
    logic res_ready;
    mult_pkg::mult_result_t res;
    mult_pkg::mult_result_t res_head;
    logic res_empty;
    logic res_pop;
    logic [mult_pkg::RESULT_COUNT_W-1:0] res_count;

    axil_mult_regs regs_inst (
        .clk(clk),
        .rst(rst),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .job_valid(job_valid),
        .job(job),
        .job_ready(job_ready),
        .res_data(res_head),
        .res_empty(res_empty),
        .res_count(res_count),
        .res_pop(res_pop)
    );

    mult_datapath datapath_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(job_valid),
        .in_job(job),
        .in_ready(job_ready),
        .out_valid(res_valid),
        .out_res(res),
        .out_ready(res_ready)
    );

    result_fifo fifo_inst (
        .clk(clk),
        .rst(rst),
        .wr_valid(res_valid),
        .wr_data(res),
        .wr_ready(res_ready),
        .pop(res_pop),
        .head(res_head),
        .empty(res_empty),
        .count(res_count)
    );

endmodule

// ==== bench/mult_top_assert.sv ====
`timescale 1ns/1ps

module mult_top_assert (
    input logic                                clk,
    input logic                                rst,
    input mult_pkg::axil_req_t                 axil_req,
    input mult_pkg::axil_rsp_t                 axil_rsp,
    input logic                                job_valid,
    input logic                                res_valid,
    input logic                                res_ready,
    input logic                                res_pop,
    input logic [mult_pkg::RESULT_COUNT_W-1:0] res_count
);

    int fail_count = 0;
    logic [mult_pkg::RESULT_COUNT_W-1:0] occupancy;

    // Results held in the FIFO, counted from its push and pop handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + mult_pkg::RESULT_COUNT_W'(res_valid && res_ready)
                         - mult_pkg::RESULT_COUNT_W'(res_pop);
        end
    end

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        (axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid && $stable(axil_rsp.b_resp))
        and (axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid &&
             $stable(axil_rsp.r_data) && $stable(axil_rsp.r_resp)))
    else begin
        $error("b or r response changed before its ready");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !(axil_rsp.b_valid || axil_rsp.r_valid || job_valid || res_valid))
    else begin
        $error("a valid was high in the first cycle after reset");
        fail_count++;
    end

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        res_count <= mult_pkg::RESULT_COUNT_W'(mult_pkg::RESULT_FIFO_DEPTH))
    else begin
        $error("result FIFO count above its depth");
        fail_count++;
    end

    no_empty_pop: assert property (@(posedge clk) disable iff (rst)
        res_pop |-> occupancy != '0)
    else begin
        $error("result FIFO popped while empty");
        fail_count++;
    end

endmodule

bind mult_top mult_top_assert mult_top_assert_inst (.*);

// ==== bench/tb_mult_top.sv ====
`timescale 1ns/1ps

module tb_mult_top;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int EXTRA_JOBS = 16; // Mode switching, back-pressure and error accesses
    localparam longint APPROX_BOUND = 64'd1 << 22;

    logic clk;
    logic rst;
    mult_pkg::axil_req_t axil_req;
    mult_pkg::axil_rsp_t axil_rsp;
    int n_tests = 0;
    int approx_diffs = 0;
    logic tardy_done;
    logic [31:0] case_mode[$];
    logic [31:0] case_x[$];
    logic [31:0] case_y[$];
    logic [31:0] case_prod[$];
    logic [15:0] rx [7];
    logic [15:0] ry [7];

    mult_top mult_top_inst (
        .clk(clk),
        .rst(rst),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (n_tests > 0);
        repeat (200 * n_tests) #CLK_PERIOD;
        abort_run("The run timed out before all tests finished");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got 0x%h expected 0x%h", $time, name, got, exp);
            abort_run("A checked value did not match");
        end
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        axil_req.aw_addr = addr;
        axil_req.w_data = data;
        axil_req.w_strb = 4'hF;
        axil_req.aw_valid = 1'b1;
        axil_req.w_valid = 1'b1;
        do @(negedge clk);
        while (!axil_rsp.aw_ready);
        check_value("w_ready with aw_ready", 32'(axil_rsp.w_ready), 32'd1);
        @(posedge clk) #DRIVE_DELAY;
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid = 1'b0;
        repeat ($urandom_range(2)) @(posedge clk) #DRIVE_DELAY; // Tardy b_ready
        axil_req.b_ready = 1'b1;
        do @(negedge clk);
        while (!axil_rsp.b_valid);
        resp = axil_rsp.b_resp;
        @(posedge clk) #DRIVE_DELAY;
        axil_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        axil_req.ar_addr = addr;
        axil_req.ar_valid = 1'b1;
        do @(negedge clk);
        while (!axil_rsp.ar_ready);
        @(posedge clk) #DRIVE_DELAY;
        axil_req.ar_valid = 1'b0;
        repeat ($urandom_range(2)) @(posedge clk) #DRIVE_DELAY;
        axil_req.r_ready = 1'b1;
        do @(negedge clk);
        while (!axil_rsp.r_valid);
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        @(posedge clk) #DRIVE_DELAY;
        axil_req.r_ready = 1'b0;
    endtask

    task automatic queue_job(input logic [15:0] x, input logic [15:0] y);
        logic [1:0] resp;
        axil_write(mult_pkg::REG_OPERANDS, {y, x}, resp);
        check_value("b_resp OPERANDS", 32'(resp), 32'(mult_pkg::AXI_RESP_OKAY));
    endtask

    // Polls STATUS until a result has arrived, then pops it
    task automatic read_result(output logic [31:0] data);
        logic [31:0] status;
        logic [1:0] resp;
        status = '0;
        while (!status[0]) begin
            axil_read(mult_pkg::REG_STATUS, status, resp);
        end
        axil_read(mult_pkg::REG_RESULT, data, resp);
        check_value("r_resp RESULT", 32'(resp), 32'(mult_pkg::AXI_RESP_OKAY));
    endtask

    function automatic logic [31:0] exact_of(input logic [15:0] x, input logic [15:0] y);
        logic signed [31:0] p;
        p = $signed(x) * $signed(y);
        return p;
    endfunction

    task automatic check_product(input logic approx, input logic [31:0] expected,
                                 input logic [31:0] got);
        longint err;
        if (approx) begin
            if (got !== expected) begin
                approx_diffs++;
            end
            err = longint'($signed(got - expected));
            if (err < 0) begin
                err = -err;
            end
            check_value("approx error below 2^22", 32'(err < APPROX_BOUND), 32'd1);
        end else begin
            check_value("RESULT product", got, expected);
        end
    endtask

    initial begin
        int fd;
        string line;
        logic [31:0] m;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] p;
        logic [31:0] data;
        logic [1:0] resp;
        void'($urandom(32'ha88177eb));
        axil_req = '0;
        rst = 1'b1;
        fd = $fopen("bench/mult_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open bench/mult_cases.txt");
        end
        void'($fgets(line, fd)); // Two column header lines
        void'($fgets(line, fd));
        while ($fscanf(fd, "%h %h %h %h\n", m, x, y, p) == 4) begin
            case_mode.push_back(m);
            case_x.push_back(x);
            case_y.push_back(y);
            case_prod.push_back(p);
        end
        $fclose(fd);
        n_tests = case_mode.size() + EXTRA_JOBS;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        foreach (case_mode[i]) begin
            axil_write(mult_pkg::REG_CTRL, case_mode[i], resp);
            queue_job(case_x[i][15:0], case_y[i][15:0]);
            read_result(data);
            check_product(case_mode[i][0], case_prod[i], data);
        end

        // Exact, approximate and exact jobs all queued before any pop
        for (int i = 0; i < 7; i++) begin
            rx[i] = 16'($urandom);
            ry[i] = 16'($urandom);
        end
        for (int i = 0; i < 3; i++) begin
            axil_write(mult_pkg::REG_CTRL, 32'(i == 1), resp);
            axil_read(mult_pkg::REG_CTRL, data, resp);
            check_value("CTRL mode", data, 32'(i == 1));
            queue_job(rx[i], ry[i]);
        end
        for (int i = 0; i < 3; i++) begin
            read_result(data);
            check_product(i == 1, exact_of(rx[i], ry[i]), data);
        end

        // Six jobs fill both stages and the FIFO, the seventh has to wait
        for (int i = 0; i < 7; i++) begin
            rx[i] = 16'($urandom);
            ry[i] = 16'($urandom);
        end
        for (int i = 0; i < 6; i++) begin
            queue_job(rx[i], ry[i]);
        end
        axil_read(mult_pkg::REG_STATUS, data, resp);
        check_value("STATUS job path full", 32'(data[1]), 32'd1);
        check_value("STATUS count", 32'(data[4:2]), 32'd4);
        tardy_done = 1'b0;
        fork
            begin
                queue_job(rx[6], ry[6]);
                tardy_done = 1'b1;
            end
        join_none
        repeat (8) @(posedge clk) #DRIVE_DELAY;
        check_value("tardy OPERANDS write done", 32'(tardy_done), 32'd0);
        for (int i = 0; i < 7; i++) begin
            read_result(data);
            check_product(1'b0, exact_of(rx[i], ry[i]), data);
            if (i == 0) begin
                wait (tardy_done);
            end
        end

        axil_read(mult_pkg::REG_STATUS, data, resp);
        check_value("STATUS result available", 32'(data[0]), 32'd0);
        axil_read(mult_pkg::REG_RESULT, data, resp);
        check_value("r_data RESULT empty", data, 32'd0);
        check_value("r_resp RESULT empty", 32'(resp), 32'(mult_pkg::AXI_RESP_SLVERR));
        axil_read(4'h2, data, resp);
        check_value("r_resp unmapped", 32'(resp), 32'(mult_pkg::AXI_RESP_SLVERR));
        check_value("approximate results unlike exact", 32'(approx_diffs > 0), 32'd1);
        repeat (2) @(posedge clk) #DRIVE_DELAY;

        if (mult_top_inst.mult_top_assert_inst.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("Bound assertions reported failures");
        end
    end

endmodule

// ==== bench/mult_cases.txt ====
# columns: mode (0 exact, 1 approximate) x y product, all hex
# product is the exact signed product of x and y
0 0003 0005 0000000f
0 8000 8000 40000000
0 1234 0000 00000000
0 0000 8000 00000000
0 7fff 7fff 3fff0001
0 8000 7fff c0008000
0 8000 ffff 00008000
0 ffff ffff 00000001
0 ffff 0001 ffffffff
0 0064 ff9c ffffd8f0
0 1234 5678 06260060
0 edcc 5678 f9d9ffa0
1 0003 0005 0000000f
1 0000 1234 00000000
1 1234 5678 06260060
1 7fff 7fff 3fff0001
1 8000 8000 40000000
1 edcc 5678 f9d9ffa0
1 0064 ff9c ffffd8f0

// ==== src.f ====
common/mult_pkg.sv
hdl/pipe_stage.sv
hdl/result_fifo.sv
mult_core/mult_approx_bw16.sv
mult_core/mult_datapath.sv
hdl/axil_mult_regs.sv
hdl/mult_top.sv
bench/mult_top_assert.sv
bench/tb_mult_top.sv

// ==== Bender.yml ====
package:
  name: mult_unit

sources:
  - common/mult_pkg.sv
  - hdl/pipe_stage.sv
  - hdl/result_fifo.sv
  - mult_core/mult_approx_bw16.sv
  - mult_core/mult_datapath.sv
  - hdl/axil_mult_regs.sv
  - hdl/mult_top.sv
  - target: test
    files:
      - bench/mult_top_assert.sv
      - bench/tb_mult_top.sv
